/* atx_pll_rcfg_macros.svh */
/*
  Widths and register map of the ATX PLL reconfiguration front end.
  Included by the packages, the RTL and the testbench.
*/
`ifndef ATX_PLL_RCFG_MACROS_SVH
`define ATX_PLL_RCFG_MACROS_SVH

// Channel count and address split of the shared port
`define RCFG_INTERFACES 2
`define RCFG_SEL_BITS   1
`define RCFG_ADDR_BITS  10

// Data widths on the user and transceiver sides
`define RCFG_DATA_WIDTH 32
`define XCVR_DATA_WIDTH 8

// Soft CSR window and its register offsets
`define CSR_SEL_BIT     9
`define CSR_STATUS_OFS  0
`define CSR_CTRL_OFS    1

`endif

/* rcfg_bus_pkg.sv */
/*
  Types of the reconfiguration bus, for the shared user port
  and the per-channel transceiver register port.
*/
`include "atx_pll_rcfg_macros.svh"

package rcfg_bus_pkg;

  // Full user address, channel select on top of the channel address
  typedef logic [`RCFG_SEL_BITS+`RCFG_ADDR_BITS-1:0] rcfg_addr_t;

  // Address inside one channel
  typedef logic [`RCFG_ADDR_BITS-1:0] chnl_addr_t;

  typedef logic [`RCFG_DATA_WIDTH-1:0] rcfg_data_t;
  typedef logic [`XCVR_DATA_WIDTH-1:0] xcvr_data_t;

  // Channel index taken from the top address bits
  typedef logic [`RCFG_SEL_BITS-1:0] chnl_sel_t;

endpackage

/* pll_csr_pkg.sv */
/*
  Types of the per-channel soft CSR: register offset, status byte
  and the read FSM states.
*/
`include "atx_pll_rcfg_macros.svh"

package pll_csr_pkg;

  // Offset inside the CSR window, the bits below the CSR select bit
  typedef logic [`CSR_SEL_BIT-1:0] csr_ofs_t;

  // Status byte layout
  // bit 0 locked, bit 1 cal_busy, bit 2 avmm_busy, bit 3 powerdown request
  typedef logic [`XCVR_DATA_WIDTH-1:0] pll_status_t;

  // A CSR read takes one wait cycle, then completes in CSR_RESP
  typedef enum logic {
    CSR_IDLE,
    CSR_RESP
  } csr_state_t;

endpackage

/* rcfg_if_split.sv */
/*
  Splits the shared reconfiguration port into per-channel requests.
  The top address bits pick the channel; its response is muxed back
  and widened to the user data width.
*/
`include "atx_pll_rcfg_macros.svh"

module rcfg_if_split import rcfg_bus_pkg::*; (
  input  logic                         reconfig_write,
  input  logic                         reconfig_read,
  input  rcfg_addr_t                   reconfig_address,
  input  rcfg_data_t                   reconfig_writedata,
  output rcfg_data_t                   reconfig_readdata,
  output logic                         reconfig_waitrequest,

  output logic [`RCFG_INTERFACES-1:0]  chnl_write,
  output logic [`RCFG_INTERFACES-1:0]  chnl_read,
  output chnl_addr_t                   chnl_address,
  output xcvr_data_t                   chnl_writedata,
  input  xcvr_data_t                   chnl_readdata [`RCFG_INTERFACES],
  input  logic [`RCFG_INTERFACES-1:0]  chnl_waitrequest
);

  chnl_sel_t  chnl_sel;
  logic       sel_valid;
  xcvr_data_t sel_byte;
  logic       sel_wait;

  assign chnl_sel  = reconfig_address[`RCFG_ADDR_BITS +: `RCFG_SEL_BITS];
  assign sel_valid = (int'(chnl_sel) < `RCFG_INTERFACES);

  // Address and the low data byte go to every channel, strobes only to one
  assign chnl_address   = reconfig_address[`RCFG_ADDR_BITS-1:0];
  assign chnl_writedata = reconfig_writedata[`XCVR_DATA_WIDTH-1:0];

  for (genvar i = 0; i < `RCFG_INTERFACES; i++) begin : g_strobe
    assign chnl_write[i] = reconfig_write & (chnl_sel == chnl_sel_t'(i));
    assign chnl_read[i]  = reconfig_read  & (chnl_sel == chnl_sel_t'(i));
  end

  // A select with no channel behind it completes at once and reads zero
  always_comb begin
    sel_byte = '0;
    sel_wait = 1'b0;
    if (sel_valid) begin
      sel_byte = chnl_readdata[chnl_sel];
      sel_wait = chnl_waitrequest[chnl_sel];
    end
  end

  assign reconfig_readdata    = {{(`RCFG_DATA_WIDTH-`XCVR_DATA_WIDTH){1'b0}}, sel_byte};
  assign reconfig_waitrequest = sel_wait;

endmodule

/* pll_status_sync.sv */
/*
  Brings one channel's PLL status bits into the reconfig clock domain
  through two flip-flop stages and packs them into the status byte.
*/
`include "atx_pll_rcfg_macros.svh"

module pll_status_sync import pll_csr_pkg::*; (
  input  logic        reconfig_clk,
  input  logic        arst_n,
  input  logic        in_pll_powerdown,
  input  logic        in_pll_locked,
  input  logic        in_pll_cal_busy,
  input  logic        in_avmm_busy,
  output pll_status_t status
);

  logic [3:0] meta_q;
  logic [3:0] sync_q;

  always_ff @(posedge reconfig_clk or negedge arst_n) begin
    if (!arst_n) begin
      meta_q <= '0;
      sync_q <= '0;
    end else begin
      meta_q <= {in_pll_powerdown, in_avmm_busy, in_pll_cal_busy, in_pll_locked};
      sync_q <= meta_q;
    end
  end

  // Upper bits of the byte are reserved
  assign status = {{(`XCVR_DATA_WIDTH-4){1'b0}}, sync_q};

endmodule

/* pll_soft_csr.sv */
/*
  Per-channel router and soft CSR. Address bit CSR_SEL_BIT low goes
  to the transceiver register port; high hits the local status and
  control registers, which can override the PLL powerdown.
*/
`include "atx_pll_rcfg_macros.svh"

module pll_soft_csr
  import rcfg_bus_pkg::*;
  import pll_csr_pkg::*;
(
  input  logic        reconfig_clk,
  input  logic        arst_n,

  // Channel request from the split
  input  logic        chnl_write,
  input  logic        chnl_read,
  input  chnl_addr_t  chnl_address,
  input  xcvr_data_t  chnl_writedata,
  output xcvr_data_t  chnl_readdata,
  output logic        chnl_waitrequest,

  // Transceiver register port
  output logic        avmm_write,
  output logic        avmm_read,
  output chnl_addr_t  avmm_address,
  output xcvr_data_t  avmm_writedata,
  input  xcvr_data_t  avmm_readdata,
  input  logic        avmm_waitrequest,

  // PLL side
  input  pll_status_t status,
  input  logic        in_pll_powerdown,
  output logic        out_pll_powerdown
);

  logic       csr_sel;
  csr_ofs_t   csr_ofs;
  logic       csr_read;
  logic       csr_write;
  logic       csr_wait;
  csr_state_t state_q;
  xcvr_data_t csr_rdata_d;
  xcvr_data_t csr_rdata_q;
  logic [1:0] ctrl_q;

  assign csr_sel = chnl_address[`CSR_SEL_BIT];
  assign csr_ofs = chnl_address[`CSR_SEL_BIT-1:0];

  assign csr_read  = chnl_read  & csr_sel;
  assign csr_write = chnl_write & csr_sel;

  // Transceiver strobes stay low while the CSR window is addressed
  assign avmm_read      = chnl_read  & ~csr_sel;
  assign avmm_write     = chnl_write & ~csr_sel;
  assign avmm_address   = chnl_address;
  assign avmm_writedata = chnl_writedata;

  // Register read mux
  always_comb begin
    case (csr_ofs)
      csr_ofs_t'(`CSR_STATUS_OFS): csr_rdata_d = status;
      csr_ofs_t'(`CSR_CTRL_OFS):   csr_rdata_d = {{(`XCVR_DATA_WIDTH-2){1'b0}}, ctrl_q};
      default:                     csr_rdata_d = '0;
    endcase
  end

  // Read FSM, one wait cycle then the registered data
  always_ff @(posedge reconfig_clk or negedge arst_n) begin
    if (!arst_n) begin
      state_q <= CSR_IDLE;
    end else begin
      case (state_q)
        CSR_IDLE: if (csr_read) state_q <= CSR_RESP;
        CSR_RESP: state_q <= CSR_IDLE;
        default:  state_q <= CSR_IDLE;
      endcase
    end
  end

  always_ff @(posedge reconfig_clk) begin
    if (state_q == CSR_IDLE && csr_read) begin
      csr_rdata_q <= csr_rdata_d;
    end
  end

  // Writes never wait, only the first read cycle does
  assign csr_wait = csr_read & (state_q == CSR_IDLE);

  // bit 0 override enable, bit 1 override value
  always_ff @(posedge reconfig_clk or negedge arst_n) begin
    if (!arst_n) begin
      ctrl_q <= '0;
    end else if (csr_write && csr_ofs == csr_ofs_t'(`CSR_CTRL_OFS)) begin
      ctrl_q <= chnl_writedata[1:0];
    end
  end

  assign out_pll_powerdown = ctrl_q[0] ? ctrl_q[1] : in_pll_powerdown;

  assign chnl_readdata    = csr_sel ? csr_rdata_q : avmm_readdata;
  assign chnl_waitrequest = csr_sel ? csr_wait    : avmm_waitrequest;

endmodule

/* atx_pll_rcfg_top.sv */
/*
  ATX PLL reconfiguration front end. One shared user port reaches
  RCFG_INTERFACES PLL channels, each with a transceiver register
  port and a soft CSR for status and powerdown override.
*/
`include "atx_pll_rcfg_macros.svh"

module atx_pll_rcfg_top
  import rcfg_bus_pkg::*;
  import pll_csr_pkg::*;
(
  input  logic                         reconfig_clk,
  input  logic                         arst_n,

  // Shared user port
  input  logic                         reconfig_write,
  input  logic                         reconfig_read,
  input  rcfg_addr_t                   reconfig_address,
  input  rcfg_data_t                   reconfig_writedata,
  output rcfg_data_t                   reconfig_readdata,
  output logic                         reconfig_waitrequest,

  // Transceiver register ports, one per channel
  output logic [`RCFG_INTERFACES-1:0]  avmm_write,
  output logic [`RCFG_INTERFACES-1:0]  avmm_read,
  output chnl_addr_t                   avmm_address   [`RCFG_INTERFACES],
  output xcvr_data_t                   avmm_writedata [`RCFG_INTERFACES],
  input  xcvr_data_t                   avmm_readdata  [`RCFG_INTERFACES],
  input  logic [`RCFG_INTERFACES-1:0]  avmm_waitrequest,

  // PLL status and control, one bit per channel
  input  logic [`RCFG_INTERFACES-1:0]  in_pll_powerdown,
  input  logic [`RCFG_INTERFACES-1:0]  in_pll_locked,
  input  logic [`RCFG_INTERFACES-1:0]  in_pll_cal_busy,
  input  logic [`RCFG_INTERFACES-1:0]  in_avmm_busy,
  output logic [`RCFG_INTERFACES-1:0]  out_pll_powerdown
);

  logic [`RCFG_INTERFACES-1:0] chnl_write;
  logic [`RCFG_INTERFACES-1:0] chnl_read;
  chnl_addr_t                  chnl_address;
  xcvr_data_t                  chnl_writedata;
  xcvr_data_t                  chnl_readdata [`RCFG_INTERFACES];
  logic [`RCFG_INTERFACES-1:0] chnl_waitrequest;
  pll_status_t                 status [`RCFG_INTERFACES];

  rcfg_if_split u_split (
    .reconfig_write       (reconfig_write),
    .reconfig_read        (reconfig_read),
    .reconfig_address     (reconfig_address),
    .reconfig_writedata   (reconfig_writedata),
    .reconfig_readdata    (reconfig_readdata),
    .reconfig_waitrequest (reconfig_waitrequest),
    .chnl_write           (chnl_write),
    .chnl_read            (chnl_read),
    .chnl_address         (chnl_address),
    .chnl_writedata       (chnl_writedata),
    .chnl_readdata        (chnl_readdata),
    .chnl_waitrequest     (chnl_waitrequest)
  );

  for (genvar i = 0; i < `RCFG_INTERFACES; i++) begin : g_chnl
    pll_status_sync u_sync (
      .reconfig_clk     (reconfig_clk),
      .arst_n           (arst_n),
      .in_pll_powerdown (in_pll_powerdown[i]),
      .in_pll_locked    (in_pll_locked[i]),
      .in_pll_cal_busy  (in_pll_cal_busy[i]),
      .in_avmm_busy     (in_avmm_busy[i]),
      .status           (status[i])
    );

    pll_soft_csr u_csr (
      .reconfig_clk      (reconfig_clk),
      .arst_n            (arst_n),
      .chnl_write        (chnl_write[i]),
      .chnl_read         (chnl_read[i]),
      .chnl_address      (chnl_address),
      .chnl_writedata    (chnl_writedata),
      .chnl_readdata     (chnl_readdata[i]),
      .chnl_waitrequest  (chnl_waitrequest[i]),
      .avmm_write        (avmm_write[i]),
      .avmm_read         (avmm_read[i]),
      .avmm_address      (avmm_address[i]),
      .avmm_writedata    (avmm_writedata[i]),
      .avmm_readdata     (avmm_readdata[i]),
      .avmm_waitrequest  (avmm_waitrequest[i]),
      .status            (status[i]),
      .in_pll_powerdown  (in_pll_powerdown[i]),
      .out_pll_powerdown (out_pll_powerdown[i])
    );
  end

endmodule

/* atx_pll_rcfg_assert.sv */
/*
  Concurrent checks on the front end's ports, bound into the top level.
*/
`include "atx_pll_rcfg_macros.svh"

module atx_pll_rcfg_assert import rcfg_bus_pkg::*; (
  input logic                        reconfig_clk,
  input logic                        arst_n,
  input logic                        reconfig_read,
  input rcfg_addr_t                  reconfig_address,
  input logic                        reconfig_waitrequest,
  input logic [`RCFG_INTERFACES-1:0] avmm_write,
  input logic [`RCFG_INTERFACES-1:0] avmm_read
);

  logic csr_rd;
  logic csr_rd_wait_q;

  assign csr_rd = reconfig_read & reconfig_address[`CSR_SEL_BIT];

  // Set while a CSR read sits in its wait cycle
  always_ff @(posedge reconfig_clk or negedge arst_n) begin
    if (!arst_n) begin
      csr_rd_wait_q <= 1'b0;
    end else begin
      csr_rd_wait_q <= csr_rd & reconfig_waitrequest;
    end
  end

  a_one_strobe: assert property (@(posedge reconfig_clk) disable iff (!arst_n)
    $onehot0({avmm_read, avmm_write}))
    else $error("more than one transceiver strobe is high");

  a_csr_no_strobe: assert property (@(posedge reconfig_clk) disable iff (!arst_n)
    reconfig_address[`CSR_SEL_BIT] |-> ({avmm_read, avmm_write} == '0))
    else $error("transceiver strobe high while the CSR window is addressed");

  a_csr_read_wait: assert property (@(posedge reconfig_clk) disable iff (!arst_n)
    (csr_rd && !csr_rd_wait_q) |-> reconfig_waitrequest ##1 !reconfig_waitrequest)
    else $error("CSR read did not wait for exactly one cycle");

endmodule

bind atx_pll_rcfg_top atx_pll_rcfg_assert u_assert (
  .reconfig_clk         (reconfig_clk),
  .arst_n               (arst_n),
  .reconfig_read        (reconfig_read),
  .reconfig_address     (reconfig_address),
  .reconfig_waitrequest (reconfig_waitrequest),
  .avmm_write           (avmm_write),
  .avmm_read            (avmm_read)
);

/* tb_atx_pll_rcfg.sv */
/*
  Testbench of the ATX PLL reconfiguration front end. LFSR stimulus drives
  the shared port, a transceiver memory per channel answers with random
  wait cycles, and a reference model predicts every read and write.
*/
`include "atx_pll_rcfg_macros.svh"

module tb_atx_pll_rcfg import rcfg_bus_pkg::*; import pll_csr_pkg::*; ();

  localparam int NCH         = `RCFG_INTERFACES;
  localparam int N_XCVR      = 24;
  localparam int N_ACCESS    = 2 * N_XCVR + 52;
  localparam int CYCLE_LIMIT = N_ACCESS * 8 + 200;

  logic        reconfig_clk = 1'b0;
  logic        arst_n;
  logic        reconfig_write;
  logic        reconfig_read;
  rcfg_addr_t  reconfig_address;
  rcfg_data_t  reconfig_writedata;
  rcfg_data_t  reconfig_readdata;
  logic        reconfig_waitrequest;
  logic [NCH-1:0] avmm_write;
  logic [NCH-1:0] avmm_read;
  logic [NCH-1:0] avmm_waitrequest;
  chnl_addr_t  avmm_address [NCH];
  xcvr_data_t  avmm_writedata [NCH];
  xcvr_data_t  avmm_readdata [NCH];
  logic [NCH-1:0] in_pll_powerdown;
  logic [NCH-1:0] in_pll_locked;
  logic [NCH-1:0] in_pll_cal_busy;
  logic [NCH-1:0] in_avmm_busy;
  logic [NCH-1:0] out_pll_powerdown;

  // Transceiver memories, reference copy and the expected transceiver access
  xcvr_data_t  xmem [NCH][1024];
  xcvr_data_t  ref_mem [NCH][1024];
  logic [1:0]  wait_cnt [NCH];
  int          exp_ch;
  chnl_addr_t  exp_addr;
  xcvr_data_t  exp_byte;

  logic [31:0] lfsr_q = 32'd78889;
  int          cycles = 0;
  int          n_tests = 0;
  int          n_checks = 0;
  int          n_errors = 0;
  int          t_chk = 0;
  int          t_err = 0;
  rcfg_addr_t  addrs [N_XCVR];

  atx_pll_rcfg_top dut (.*);

  always #5 reconfig_clk = ~reconfig_clk;

  // Galois LFSR, one step per bit
  function automatic logic lfsr_bit();
    logic b;
    b = lfsr_q[0];
    lfsr_q = lfsr_q >> 1;
    if (b) begin
      lfsr_q = lfsr_q ^ 32'h8020_0003;
    end
    return b;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[30:0], lfsr_bit()};
    end
    return r;
  endfunction

  // Initial memory content, mixes every address bit and the channel
  function automatic xcvr_data_t fill_byte(input int c, input int a);
    return xcvr_data_t'(a ^ (a >> 8) ^ (c * 8'h5b));
  endfunction

  function automatic rcfg_addr_t make_addr(input int ch, input logic csr, input int ofs);
    rcfg_addr_t a;
    a = '0;
    a[`RCFG_ADDR_BITS +: `RCFG_SEL_BITS] = chnl_sel_t'(ch);
    a[`CSR_SEL_BIT] = csr;
    a[`CSR_SEL_BIT-1:0] = csr_ofs_t'(ofs);
    return a;
  endfunction

  function automatic rcfg_data_t expect_xcvr(input rcfg_addr_t a);
    return rcfg_data_t'(ref_mem[int'(a[`RCFG_ADDR_BITS +: `RCFG_SEL_BITS])]
                               [a[`RCFG_ADDR_BITS-1:0]]);
  endfunction

  task automatic check_data(input string name, input rcfg_data_t exp, input rcfg_data_t act);
    n_checks++;
    if (act !== exp) begin
      n_errors++;
      $display("Mismatch %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_powerdown(input string name, input logic exp, input logic act);
    n_checks++;
    if (act !== exp) begin
      n_errors++;
      $display("Mismatch %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  task automatic report_test(input string name);
    $display("%s: %0d checks, %0d errors", name, n_checks - t_chk, n_errors - t_err);
    n_tests++;
    t_chk = n_checks;
    t_err = n_errors;
  endtask

  // Called one unit after a rising edge; returns at the same point after completion
  task automatic bus_access(input logic wr, input rcfg_addr_t a, input rcfg_data_t d,
                            output rcfg_data_t rd);
    logic done;
    done = 1'b0;
    rd = '0;
    exp_ch = a[`CSR_SEL_BIT] ? -1 : int'(a[`RCFG_ADDR_BITS +: `RCFG_SEL_BITS]);
    exp_addr = a[`RCFG_ADDR_BITS-1:0];
    exp_byte = d[`XCVR_DATA_WIDTH-1:0];
    reconfig_write = wr;
    reconfig_read = ~wr;
    reconfig_address = a;
    reconfig_writedata = d;
    while (!done) begin
      @(negedge reconfig_clk);
      if (!reconfig_waitrequest) begin
        rd = reconfig_readdata;
        done = 1'b1;
      end
    end
    @(posedge reconfig_clk);
    #1;
    reconfig_write = 1'b0;
    reconfig_read = 1'b0;
  endtask

  // Transceiver model: wait count is drawn ahead, an access completes at zero
  always_comb begin
    for (int c = 0; c < NCH; c++) begin
      avmm_readdata[c] = xmem[c][avmm_address[c]];
      avmm_waitrequest[c] = (wait_cnt[c] != 2'd0);
    end
  end

  always @(posedge reconfig_clk) begin
    for (int c = 0; c < NCH; c++) begin
      if (avmm_read[c] || avmm_write[c]) begin
        if (wait_cnt[c] != 2'd0) begin
          wait_cnt[c] <= wait_cnt[c] - 2'd1;
        end else begin
          if (c != exp_ch || avmm_address[c] !== exp_addr) begin
            n_errors++;
            $display("Error: unexpected transceiver access on channel %0d at address %h",
                     c, avmm_address[c]);
          end
          if (avmm_write[c]) begin
            check_data("xcvr_write_data", rcfg_data_t'(exp_byte), rcfg_data_t'(avmm_writedata[c]));
            xmem[c][avmm_address[c]] <= avmm_writedata[c];
          end
          wait_cnt[c] <= 2'(rand_bits(2));
        end
      end
    end
  end

  always @(posedge reconfig_clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
      $display("*** FAILED ***");
      $finish;
    end
  end

  initial begin
    rcfg_data_t rd;
    rcfg_data_t wdata;
    logic [3:0] stat;
    int         ch;
    int         ofs;
    int         other;
    arst_n = 1'b0;
    reconfig_write = 1'b0;
    reconfig_read = 1'b0;
    reconfig_address = '0;
    reconfig_writedata = '0;
    in_pll_powerdown = '0;
    in_pll_locked = '0;
    in_pll_cal_busy = '0;
    in_avmm_busy = '0;
    exp_ch = -1;
    exp_addr = '0;
    exp_byte = '0;
    for (int c = 0; c < NCH; c++) begin
      wait_cnt[c] = 2'd0;
      for (int a = 0; a < 1024; a++) begin
        xmem[c][a] = fill_byte(c, a);
        ref_mem[c][a] = fill_byte(c, a);
      end
    end
    repeat (5) @(posedge reconfig_clk);
    #1;
    arst_n = 1'b1;

    for (int c = 0; c < NCH; c++) begin
      bus_access(1'b0, make_addr(c, 1'b1, `CSR_CTRL_OFS), '0, rd);
      check_data("ctrl_reset_unmapped", '0, rd);
      for (int k = 0; k < 3; k++) begin
        ofs = 2 + int'(rand_bits(8));
        bus_access(1'b1, make_addr(c, 1'b1, ofs), rand_bits(32), rd);
        bus_access(1'b0, make_addr(c, 1'b1, ofs), '0, rd);
        check_data("ctrl_reset_unmapped", '0, rd);
      end
      bus_access(1'b0, make_addr(c, 1'b1, `CSR_CTRL_OFS), '0, rd);
      check_data("ctrl_reset_unmapped", '0, rd);
    end
    report_test("ctrl_reset_unmapped");

    for (int i = 0; i < N_XCVR; i++) begin
      ch = int'(rand_bits(1));
      ofs = int'(rand_bits(9));
      wdata = rand_bits(32);
      addrs[i] = make_addr(ch, 1'b0, ofs);
      ref_mem[ch][ofs] = wdata[7:0];
      bus_access(1'b1, addrs[i], wdata, rd);
    end
    for (int i = 0; i < N_XCVR; i++) begin
      bus_access(1'b0, addrs[i], rand_bits(32), rd);
      check_data("xcvr_rw", expect_xcvr(addrs[i]), rd);
    end
    report_test("xcvr_rw");

    // Same offset, a different byte per channel
    for (int k = 0; k < 4; k++) begin
      ofs = int'(rand_bits(9));
      wdata = rand_bits(32);
      for (int c = 0; c < NCH; c++) begin
        ref_mem[c][ofs] = wdata[7:0] ^ xcvr_data_t'(c);
        bus_access(1'b1, make_addr(c, 1'b0, ofs), wdata ^ rcfg_data_t'(c), rd);
      end
      for (int c = 0; c < NCH; c++) begin
        bus_access(1'b0, make_addr(c, 1'b0, ofs), '0, rd);
        check_data("chnl_isolation", expect_xcvr(make_addr(c, 1'b0, ofs)), rd);
      end
    end
    for (int c = 0; c < NCH; c++) begin
      for (int a = 0; a < 1024; a++) begin
        check_data("chnl_isolation", rcfg_data_t'(ref_mem[c][a]), rcfg_data_t'(xmem[c][a]));
      end
    end
    report_test("chnl_isolation");

    for (int k = 0; k < 4; k++) begin
      for (int c = 0; c < NCH; c++) begin
        stat = 4'(rand_bits(4));
        {in_pll_powerdown[c], in_avmm_busy[c], in_pll_cal_busy[c], in_pll_locked[c]} = stat;
        repeat (3) @(posedge reconfig_clk);
        #1;
        bus_access(1'b0, make_addr(c, 1'b1, `CSR_STATUS_OFS), '0, rd);
        check_data("csr_status", rcfg_data_t'(stat), rd);
      end
    end
    report_test("csr_status");

    for (int c = 0; c < NCH; c++) begin
      other = (c + 1) % NCH;
      for (int v = 0; v < 2; v++) begin
        bus_access(1'b1, make_addr(c, 1'b1, `CSR_CTRL_OFS), rcfg_data_t'(2 * v + 1), rd);
        in_pll_powerdown = ~in_pll_powerdown;
        @(negedge reconfig_clk);
        check_powerdown("powerdown_override", v[0], out_pll_powerdown[c]);
        check_powerdown("powerdown_override", in_pll_powerdown[other], out_pll_powerdown[other]);
        @(posedge reconfig_clk);
        #1;
        bus_access(1'b0, make_addr(c, 1'b1, `CSR_CTRL_OFS), '0, rd);
        check_data("powerdown_override", rcfg_data_t'(2 * v + 1), rd);
        bus_access(1'b1, make_addr(c, 1'b1, `CSR_CTRL_OFS), '0, rd);
        in_pll_powerdown[c] = ~in_pll_powerdown[c];
        @(negedge reconfig_clk);
        check_powerdown("powerdown_override", in_pll_powerdown[c], out_pll_powerdown[c]);
        @(posedge reconfig_clk);
        #1;
      end
    end
    report_test("powerdown_override");

    $display("tests %0d, checks %0d, errors %0d", n_tests, n_checks, n_errors);
    if (n_errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

/* filelist.f */
+incdir+.
rcfg_bus_pkg.sv
pll_csr_pkg.sv
rcfg_if_split.sv
pll_status_sync.sv
pll_soft_csr.sv
atx_pll_rcfg_top.sv
atx_pll_rcfg_assert.sv
tb_atx_pll_rcfg.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_atx_pll_rcfg
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  := *** FAILED ***

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -qF '$(FAIL_MSG)' $(LOG); then \
	  echo "Simulation failed"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
